/* Makefile */
TOP := cpu_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
+incdir+.
cpuPkg.sv
regFile.sv
aluUnit.sv
controlFsm.sv
datapath.sv
multiCycleCpu.sv
cpu_assertions.sv
cpu_tb.sv

/* aluUnit.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module aluUnit (
	input  logic [`XLEN-1:0] operandA,
	input  logic [`XLEN-1:0] operandB,
	input  cpuPkg::aluModeT  mode,
	input  logic [2:0]       funct3,
	input  logic             funct7Alt,
	input  logic             isImmOp,
	output logic [`XLEN-1:0] result,
	output logic             zero
);
	import cpuPkg::*;

	logic [$clog2(`XLEN)-1:0] shamt;
	logic                     lessThan;

	assign shamt    = operandB[$clog2(`XLEN)-1:0];
	assign lessThan = $signed(operandA) < $signed(operandB);

	always_comb begin
		result = operandA + operandB;
		case (mode)
			aluCompare: result = operandA - operandB;
			aluFunct: begin
				case (funct3)
					3'b000:  result = (funct7Alt && !isImmOp) ? operandA - operandB
						: operandA + operandB;
					3'b001:  result = operandA << shamt;
					3'b010:  result = {{(`XLEN-1){1'b0}}, lessThan};
					3'b100:  result = operandA ^ operandB;
					3'b101:  result = operandA >> shamt;
					3'b110:  result = operandA | operandB;
					3'b111:  result = operandA & operandB;
					default: result = operandA + operandB;
				endcase
			end
			default: result = operandA + operandB;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* controlFsm.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlFsm (
	input  logic                CLK,
	input  logic                rst,
	input  logic [6:0]          opcode,
	output logic                pcWrite,
	output logic                pcWriteCond,
	output logic                irWrite,
	output logic                regWrite,
	output logic                memToReg,
	output logic                memWrite,
	output logic                aluSrcA,
	output logic [1:0]          aluSrcB,
	output cpuPkg::aluModeT     aluMode,
	output logic [1:0]          pcSource,
	output logic [`XLEN-1:0]    retired
);
	import cpuPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	logic      lastState; // Instruction completes at this edge

	always_ff @(posedge CLK) begin
		if (rst) begin
			state   <= stFetch;
			retired <= '0;
		end else begin
			state <= nextState;
			if (lastState)
				retired <= retired + 1'b1;
		end
	end

	always_comb begin
		pcWrite     = 1'b0;
		pcWriteCond = 1'b0;
		irWrite     = 1'b0;
		regWrite    = 1'b0;
		memToReg    = 1'b0;
		memWrite    = 1'b0;
		aluSrcA     = 1'b0;  // PC
		aluSrcB     = 2'd0;  // Register B
		aluMode     = aluAdd;
		pcSource    = 2'd0;  // ALU result
		lastState   = 1'b0;
		nextState   = state;
		case (state)
			stFetch: begin
				irWrite   = 1'b1;
				pcWrite   = 1'b1;
				aluSrcB   = 2'd1; // PC + 4
				nextState = stDecode;
			end
			stDecode: begin
				aluSrcB = 2'd2; // Branch/jal target into ALU register
				case (opcode)
					`OP_RTYPE:  nextState = stExecAlu;
					`OP_ITYPE:  nextState = stExecImm;
					`OP_LOAD:   nextState = stExecAddr;
					`OP_STORE:  nextState = stExecAddr;
					`OP_BRANCH: nextState = stExecBranch;
					`OP_JAL:    nextState = stExecJal;
					`OP_JALR:   nextState = stExecJalr;
					default:    nextState = stFetch; // Unknown opcode, not retired
				endcase
			end
			stExecAlu: begin
				aluSrcA   = 1'b1;
				aluMode   = aluFunct;
				nextState = stWriteAlu;
			end
			stExecImm: begin
				aluSrcA   = 1'b1;
				aluSrcB   = 2'd2;
				aluMode   = aluFunct;
				nextState = stWriteAlu;
			end
			stExecAddr: begin
				aluSrcA   = 1'b1;
				aluSrcB   = 2'd2;
				nextState = (opcode == `OP_LOAD) ? stMemRead : stMemWrite;
			end
			stExecBranch: begin
				aluSrcA     = 1'b1;
				aluMode     = aluCompare;
				pcWriteCond = 1'b1;
				pcSource    = 2'd1;
				lastState   = 1'b1;
				nextState   = stFetch;
			end
			stExecJal: begin
				regWrite  = 1'b1; // Link value is PC + 4
				pcWrite   = 1'b1;
				pcSource  = 2'd1;
				lastState = 1'b1;
				nextState = stFetch;
			end
			stExecJalr: begin
				aluSrcA   = 1'b1;
				aluSrcB   = 2'd2;
				regWrite  = 1'b1;
				pcWrite   = 1'b1;
				pcSource  = 2'd2;
				lastState = 1'b1;
				nextState = stFetch;
			end
			stMemRead: begin
				nextState = stWriteMem;
			end
			stMemWrite: begin
				memWrite  = 1'b1;
				lastState = 1'b1;
				nextState = stFetch;
			end
			stWriteAlu: begin
				regWrite  = 1'b1;
				lastState = 1'b1;
				nextState = stFetch;
			end
			stWriteMem: begin
				regWrite  = 1'b1;
				memToReg  = 1'b1;
				lastState = 1'b1;
				nextState = stFetch;
			end
			default: begin
				nextState = stFetch;
			end
		endcase
	end

endmodule

/* cpuPkg.sv */
package cpuPkg;

	typedef enum logic [3:0] {
		stFetch, stDecode,
		stExecAlu, stExecImm, stExecAddr, stExecBranch, stExecJal, stExecJalr,
		stMemRead, stMemWrite,
		stWriteAlu, stWriteMem
	} ctrlStateT;

	typedef enum logic [1:0] {
		aluAdd,     // Address and PC arithmetic
		aluFunct,   // From funct3/funct7
		aluCompare  // Subtract for branch compare
	} aluModeT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFormatT;

	typedef struct packed {
		logic [11:0] imm11to0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iFormatT;

	typedef struct packed {
		logic [6:0] imm11to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4to0;
		logic [6:0] opcode;
	} sFormatT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bFormatT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFormatT;

	// One fetched word, viewed in whichever format the opcode calls for
	typedef union packed {
		rFormatT r;
		iFormatT i;
		sFormatT s;
		bFormatT b;
		jFormatT j;
	} instrWordT;

endpackage

/* cpu_assertions.sv */
`timescale 1ns/1ps

module cpuAssertions (
	input logic              CLK,
	input logic              rst,
	input cpuPkg::ctrlStateT state,
	input logic              regWrite,
	input logic              memWrite
);
	import cpuPkg::*;

	localparam int maxAway = 4; // lw spends four states away from fetch

	logic [3:0] awayCount;
	int         failCount = 0;

	always_ff @(posedge CLK) begin
		if (rst || state == stFetch)
			awayCount <= '0;
		else if (awayCount != 4'hf)
			awayCount <= awayCount + 4'd1;
	end

	assert property (@(posedge CLK) disable iff (rst) memWrite |-> state == stMemWrite)
		else begin
			$error("memWrite asserted outside stMemWrite");
			failCount++;
		end

	assert property (@(posedge CLK) disable iff (rst) !(regWrite && memWrite))
		else begin
			$error("regWrite and memWrite high together");
			failCount++;
		end

	// Back in fetch no later than the fifth cycle
	assert property (@(posedge CLK) disable iff (rst) state != stFetch |-> awayCount < maxAway)
		else begin
			$error("controller did not return to stFetch in time");
			failCount++;
		end

endmodule

bind controlFsm cpuAssertions cpuAssertions_i (
	.CLK      (CLK),
	.rst      (rst),
	.state    (state),
	.regWrite (regWrite),
	.memWrite (memWrite)
);

/* cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath width and register file size
`define XLEN      32
`define REG_COUNT 32

`define RESET_PC  32'h0000_0000

// RV32I major opcodes for the supported subset
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

`endif

/* cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;
	import cpuPkg::*;

	localparam int memWords  = 64;
	localparam int stepLimit = 200; // Cycles allowed between two stores
	localparam logic [31:0] skipAddr = 32'h0000_00f0;

	logic             CLK;
	logic             rst;
	logic [`XLEN-1:0] iAddr, iRdata, dAddr, dWdata, dRdata, retired;
	logic             dWe;

	logic [31:0] imem [memWords];
	logic [31:0] dmem [memWords];
	logic [31:0] progWords [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] lfsrState;
	logic [31:0] storeAddr;
	logic [31:0] loopPc;
	int          execCount;

	multiCycleCpu dut_i (
		.CLK     (CLK),
		.rst     (rst),
		.iAddr   (iAddr),
		.iRdata  (iRdata),
		.dAddr   (dAddr),
		.dWdata  (dWdata),
		.dWe     (dWe),
		.dRdata  (dRdata),
		.retired (retired)
	);

	always #20 CLK = ~CLK;

	assign iRdata = imem[iAddr[7:2]];
	assign dRdata = dmem[dAddr[7:2]];

	always @(posedge CLK) begin
		if (dWe)
			dmem[dAddr[7:2]] <= dWdata;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		logic        feedback;
		int          k;
		value = '0;
		for (k = 0; k < count; k++) begin
			feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value     = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] regOp(input logic [6:0] funct7, input logic [2:0] funct3);
		instrWordT word;
		word.r = '{funct7, 5'd2, 5'd1, funct3, 5'd3, `OP_RTYPE}; // x3 = x1 op x2
		return word;
	endfunction

	function automatic logic [31:0] immOp(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
		instrWordT word;
		word.i = '{imm, rs1, funct3, rd, opcode};
		return word;
	endfunction

	function automatic logic [31:0] storeOp(input logic [11:0] imm, input logic [4:0] rs2);
		instrWordT word;
		word.s = '{imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `OP_STORE};
		return word;
	endfunction

	function automatic logic [31:0] branchOp(input logic [12:0] offset, input logic [4:0] rs2,
			input logic [2:0] funct3);
		instrWordT word;
		word.b = '{offset[12], offset[10:5], rs2, 5'd1, funct3, offset[4:1], offset[11],
			`OP_BRANCH};
		return word;
	endfunction

	function automatic logic [31:0] jumpOp(input logic [20:0] offset, input logic [4:0] rd);
		instrWordT word;
		word.j = '{offset[20], offset[10:1], offset[11], offset[19:12], rd, `OP_JAL};
		return word;
	endfunction

	function automatic logic [31:0] pcNow();
		return `RESET_PC + progWords.size() * 4;
	endfunction

	task automatic emit(input logic [31:0] word, input bit runs);
		progWords.push_back(word);
		if (runs)
			execCount++;
	endtask

	task automatic storeChecked(input logic [4:0] rs2, input logic [31:0] data);
		emit(storeOp(storeAddr[11:0], rs2), 1);
		expAddr.push_back(storeAddr);
		expData.push_back(data);
		storeAddr += 4;
	endtask

	task automatic runAlu(input logic [31:0] word, input logic [31:0] data);
		emit(word, 1);
		storeChecked(5'd3, data);
	endtask

	task automatic buildProgram(input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] moved);
		logic [11:0] imm;
		logic [31:0] ext;
		logic [4:0]  sh;
		logic [31:0] linkPc;
		logic [31:0] target;
		imm = 12'(randBits(12)) | 12'h400; // Bit 10 set so addi must not subtract
		sh  = 5'(randBits(5));
		ext = {{20{imm[11]}}, imm};
		emit(immOp(12'h000, 5'd0, 3'b010, 5'd1, `OP_LOAD), 1);
		emit(immOp(12'h004, 5'd0, 3'b010, 5'd2, `OP_LOAD), 1);
		runAlu(regOp(7'h00, 3'b000), a + b);
		runAlu(regOp(7'h20, 3'b000), a - b);
		runAlu(regOp(7'h00, 3'b111), a & b);
		runAlu(regOp(7'h00, 3'b110), a | b);
		runAlu(regOp(7'h00, 3'b100), a ^ b);
		runAlu(regOp(7'h00, 3'b010), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		runAlu(regOp(7'h00, 3'b001), a << b[4:0]);
		runAlu(regOp(7'h00, 3'b101), a >> b[4:0]);
		runAlu(immOp(imm, 5'd1, 3'b000, 5'd3, `OP_ITYPE), a + ext);
		runAlu(immOp(imm, 5'd1, 3'b100, 5'd3, `OP_ITYPE), a ^ ext);
		runAlu(immOp(imm, 5'd1, 3'b110, 5'd3, `OP_ITYPE), a | ext);
		runAlu(immOp(imm, 5'd1, 3'b111, 5'd3, `OP_ITYPE), a & ext);
		runAlu(immOp(imm, 5'd1, 3'b010, 5'd3, `OP_ITYPE),
			($signed(a) < $signed(ext)) ? 32'd1 : 32'd0);
		runAlu(immOp({7'd0, sh}, 5'd1, 3'b001, 5'd3, `OP_ITYPE), a << sh);
		runAlu(immOp({7'd0, sh}, 5'd1, 3'b101, 5'd3, `OP_ITYPE), a >> sh);
		emit(immOp(12'h008, 5'd0, 3'b010, 5'd5, `OP_LOAD), 1);
		storeChecked(5'd5, moved);
		emit(branchOp(13'd8, 5'd1, 3'b000), 1); // beq taken
		emit(storeOp(skipAddr[11:0], 5'd0), 0);
		emit(branchOp(13'd8, 5'd2, 3'b000), 1); // beq falls through
		storeChecked(5'd1, a);
		emit(branchOp(13'd8, 5'd2, 3'b001), 1); // bne taken
		emit(storeOp(skipAddr[11:0], 5'd0), 0);
		emit(branchOp(13'd8, 5'd1, 3'b001), 1); // bne falls through
		storeChecked(5'd2, b);
		linkPc = pcNow() + 4;
		emit(jumpOp(21'd8, 5'd6), 1);
		emit(storeOp(skipAddr[11:0], 5'd0), 0);
		storeChecked(5'd6, linkPc);
		target = pcNow() + 12; // Past addi, jalr and the skipped store
		emit(immOp(target[11:0], 5'd0, 3'b000, 5'd7, `OP_ITYPE), 1);
		linkPc = pcNow() + 4;
		emit(immOp(12'd1, 5'd7, 3'b000, 5'd8, `OP_JALR), 1); // Odd target loses bit 0
		emit(storeOp(skipAddr[11:0], 5'd0), 0);
		storeChecked(5'd8, linkPc);
		loopPc = pcNow();
		emit(jumpOp(21'd0, 5'd0), 0);
	endtask

	task automatic abortRun();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("ERR %0t ns %s: got %h, expected %h", $time, name, got, want);
			abortRun();
		end
	endtask

	initial begin
		logic [31:0] opA, opB, moved;
		int          i;
		int          waited;
		CLK       = 1'b0;
		rst       = 1'b1;
		lfsrState = 32'h64c11537;
		execCount = 0;
		storeAddr = 32'h0000_0040;
		opA       = randBits(32);
		opB       = randBits(32);
		moved     = randBits(32);
		if (opB == opA)
			opB = ~opA; // Branch cases need two distinct values
		for (i = 0; i < memWords; i++) begin
			imem[i] = (i * 4) * 32'h9e37_79b1 + 32'h0bad_5eed;
			dmem[i] = (i * 4) * 32'h9e37_79b1 + 32'h0bad_5eed;
		end
		buildProgram(opA, opB, moved);
		for (i = 0; i < progWords.size(); i++)
			imem[i] = progWords[i];
		dmem[0] = opA;
		dmem[1] = opB;
		dmem[2] = moved;

		repeat (5) @(negedge CLK);
		compare("iAddr", iAddr, `RESET_PC);
		compare("retired", retired, 32'd0);
		compare("dWe", 32'(dWe), 32'd0);
		rst = 1'b0;

		for (i = 0; i < expAddr.size(); i++) begin
			waited = 0;
			do begin
				@(negedge CLK);
				waited++;
			end while (!dWe && waited < stepLimit);
			if (!dWe) begin
				$display("Timeout: store %0d was never issued", i);
				abortRun();
			end
			compare("dAddr", dAddr, expAddr[i]);
			compare("dWdata", dWdata, expData[i]);
		end

		@(negedge CLK); // Fetch of the final self-loop
		compare("retired", retired, execCount);
		compare("iAddr", iAddr, loopPc);
		if (dut_i.controlFsm_i.cpuAssertions_i.failCount != 0) begin
			$display("Controller assertions failed during the run");
			abortRun();
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

/* datapath.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath (
	input  logic             CLK,
	input  logic             rst,
	input  logic             pcWrite,
	input  logic             pcWriteCond,
	input  logic             irWrite,
	input  logic             regWrite,
	input  logic             memToReg,
	input  logic             aluSrcA,
	input  logic [1:0]       aluSrcB,
	input  cpuPkg::aluModeT  aluMode,
	input  logic [1:0]       pcSource,
	output logic [6:0]       opcode,
	output logic [`XLEN-1:0] iAddr,
	input  logic [`XLEN-1:0] iRdata,
	output logic [`XLEN-1:0] dAddr,
	output logic [`XLEN-1:0] dWdata,
	input  logic [`XLEN-1:0] dRdata
);
	import cpuPkg::*;

	instrWordT        ir;
	logic [`XLEN-1:0] pc, instrPc, regA, regB, aluOut, mdr;
	logic [`XLEN-1:0] rfData1, rfData2, imm, srcA, srcB, aluResult, wbData, pcNext;
	logic [$clog2(`REG_COUNT)-1:0] rs1Idx, rs2Idx, rdIdx;
	logic             zero, branchTaken, isLink;

	assign opcode = ir.r.opcode;
	assign rs1Idx = ir.r.rs1;
	assign rs2Idx = ir.r.rs2;
	assign rdIdx  = ir.r.rd;
	assign isLink = (opcode == `OP_JAL) || (opcode == `OP_JALR);

	always_comb begin
		case (opcode)
			`OP_STORE:  imm = {{(`XLEN-12){ir.s.imm11to5[6]}}, ir.s.imm11to5, ir.s.imm4to0};
			`OP_BRANCH: imm = {{(`XLEN-13){ir.b.imm12}}, ir.b.imm12, ir.b.imm11,
				ir.b.imm10to5, ir.b.imm4to1, 1'b0};
			`OP_JAL:    imm = {{(`XLEN-21){ir.j.imm20}}, ir.j.imm20, ir.j.imm19to12,
				ir.j.imm11, ir.j.imm10to1, 1'b0};
			default:    imm = {{(`XLEN-12){ir.i.imm11to0[11]}}, ir.i.imm11to0};
		endcase
	end

	// Fetch adds to the live PC, later states use the fetched instruction's PC
	assign srcA = aluSrcA ? regA : (irWrite ? pc : instrPc);

	always_comb begin
		case (aluSrcB)
			2'd0:    srcB = regB;
			2'd1:    srcB = `XLEN'd4;
			default: srcB = imm;
		endcase
	end

	always_comb begin
		case (pcSource)
			2'd1:    pcNext = aluOut;
			2'd2:    pcNext = {aluResult[`XLEN-1:1], 1'b0}; // jalr clears bit 0
			default: pcNext = aluResult;
		endcase
	end

	assign branchTaken = ir.b.funct3[0] ? ~zero : zero; // bne : beq
	assign wbData      = isLink ? pc : (memToReg ? mdr : aluOut);

	always_ff @(posedge CLK) begin
		if (rst)
			pc <= `RESET_PC;
		else if (pcWrite || (pcWriteCond && branchTaken))
			pc <= pcNext;
	end

	always_ff @(posedge CLK) begin
		if (irWrite) begin
			ir      <= iRdata;
			instrPc <= pc;
		end
		regA   <= rfData1;
		regB   <= rfData2;
		aluOut <= aluResult;
		mdr    <= dRdata;
	end

	assign iAddr  = pc;
	assign dAddr  = aluOut;
	assign dWdata = regB;

	regFile regFile_i (
		.CLK       (CLK),
		.rs1       (rs1Idx),
		.rs2       (rs2Idx),
		.rd        (rdIdx),
		.writeEn   (regWrite),
		.writeData (wbData),
		.readData1 (rfData1),
		.readData2 (rfData2)
	);

	aluUnit aluUnit_i (
		.operandA  (srcA),
		.operandB  (srcB),
		.mode      (aluMode),
		.funct3    (ir.r.funct3),
		.funct7Alt (ir.r.funct7[5]),
		.isImmOp   (opcode == `OP_ITYPE),
		.result    (aluResult),
		.zero      (zero)
	);

endmodule

/* multiCycleCpu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module multiCycleCpu (
	input  logic             CLK,
	input  logic             rst,
	output logic [`XLEN-1:0] iAddr,
	input  logic [`XLEN-1:0] iRdata,
	output logic [`XLEN-1:0] dAddr,
	output logic [`XLEN-1:0] dWdata,
	output logic             dWe,
	input  logic [`XLEN-1:0] dRdata,
	output logic [`XLEN-1:0] retired
);
	import cpuPkg::*;

	logic       pcWrite, pcWriteCond, irWrite, regWrite, memToReg, aluSrcA;
	logic [1:0] aluSrcB, pcSource;
	logic [6:0] opcode;
	aluModeT    aluMode;

	controlFsm controlFsm_i (
		.CLK (CLK), .rst (rst), .opcode (opcode),
		.pcWrite (pcWrite), .pcWriteCond (pcWriteCond), .irWrite (irWrite),
		.regWrite (regWrite), .memToReg (memToReg), .memWrite (dWe),
		.aluSrcA (aluSrcA), .aluSrcB (aluSrcB), .aluMode (aluMode),
		.pcSource (pcSource), .retired (retired)
	);

	datapath datapath_i (
		.CLK (CLK), .rst (rst),
		.pcWrite (pcWrite), .pcWriteCond (pcWriteCond), .irWrite (irWrite),
		.regWrite (regWrite), .memToReg (memToReg),
		.aluSrcA (aluSrcA), .aluSrcB (aluSrcB), .aluMode (aluMode),
		.pcSource (pcSource), .opcode (opcode),
		.iAddr (iAddr), .iRdata (iRdata),
		.dAddr (dAddr), .dWdata (dWdata), .dRdata (dRdata)
	);

endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
	input  logic             CLK,
	input  logic [4:0]       rs1,
	input  logic [4:0]       rs2,
	input  logic [4:0]       rd,
	input  logic             writeEn,
	input  logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] readData1,
	output logic [`XLEN-1:0] readData2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge CLK) begin
		if (writeEn && rd != 5'd0)
			regs[rd] <= writeData;
	end

	// x0 always reads as zero
	assign readData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign readData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule
